// File: all.f
logic/shared_mem_pkg.sv
logic/dpram.sv
logic/fake_dpram.sv
logic/hog_monitor.sv
logic/shared_mem_top.sv
verification/shared_mem_asserts.sv
verification/shared_mem_tb.sv

// File: Bender.yml
package:
  name: shared_mem

sources:
  - logic/shared_mem_pkg.sv
  - logic/dpram.sv
  - logic/fake_dpram.sv
  - logic/hog_monitor.sv
  - logic/shared_mem_top.sv
  - target: test
    files:
      - verification/shared_mem_asserts.sv
      - verification/shared_mem_tb.sv

// File: verification/shared_mem_tb.sv
// --------------------
// Shared scratch memory testbench
// LFSR driven two-port traffic, checked against
// a memory and hog status model every cycle
// --------------------

`timescale 1ns/1ps

module shared_mem_tb;

	import shared_mem_pkg::*;

	logic              clk;
	logic              arst_n;
	mem_req_t          req1;
	mem_req_t          req2;
	logic              hog_clear;
	logic [mem_dw-1:0] dout1;
	logic [mem_dw-1:0] dout2;
	logic              hog_err;
	hog_status_t       status;

	// Random source
	logic [31:0] lfsr;

	// Requests driven one cycle back
	mem_req_t p1;
	mem_req_t p2;

	// Reference model
	logic [mem_dw-1:0] mem_model [logic [mem_aw-1:0]];
	logic              exp_hog;
	hog_status_t       exp_status;
	// Expected dout1, one stage
	logic [mem_dw-1:0] line1;
	// Expected dout2, two stages
	logic [mem_dw-1:0] line2 [2];

	shared_mem_top UUT (
		.clk       (clk),
		.arst_n    (arst_n),
		.req1      (req1),
		.req2      (req2),
		.hog_clear (hog_clear),
		.dout1     (dout1),
		.dout2     (dout2),
		.hog_err   (hog_err),
		.status    (status)
	);

	initial begin
		clk = 1'b0;
		forever begin
			#5 clk = ~clk;
		end
	end

	// Fibonacci LFSR, taps 32 22 2 1
	function automatic logic [31:0] lfsr_next(input logic [31:0] s);
		logic fb;
		fb = s[31] ^ s[21] ^ s[1] ^ s[0];
		return {s[30:0], fb};
	endfunction

	// One step per bit taken
	function automatic logic [31:0] take_bits(input int n);
		logic [31:0] r;
		r = '0;
		for (int i = 0; i < n; i++) begin
			lfsr = lfsr_next(lfsr);
			r = {r[30:0], lfsr[0]};
		end
		return r;
	endfunction

	// Random request, with legal set a strobe from the last cycle is not repeated
	function automatic mem_req_t random_req(input mem_req_t last, input logic legal);
		mem_req_t    r;
		logic [31:0] b;
		b = take_bits(1);
		// Half the addresses fall in a 16 word window for collisions
		b = b[0] ? take_bits(4) : take_bits(mem_aw);
		r.addr = b[mem_aw-1:0];
		b = take_bits(mem_dw);
		r.din = b[mem_dw-1:0];
		b = take_bits(2);
		r.wen = b[0] & ~(legal & last.wen);
		r.ren = b[1] & ~(legal & last.ren);
		return r;
	endfunction

	task automatic check_value(input string name, input logic [31:0] got,
		input logic [31:0] exp);
		if (got !== exp) begin
			$display("mismatch at %0t: %s is %h, expected %h", $time, name, got, exp);
			$display("Testbench failed");
			$fatal(1, "stopped at first error");
		end
	endtask

	// Model of the rising edge that samples n1, n2 and clr
	task automatic model_edge(input mem_req_t n1, input mem_req_t n2, input logic clr);
		logic [mem_dw-1:0] v1;
		logic [mem_dw-1:0] v2;
		logic              both_rd;
		exp_hog = (n1.wen & p1.wen) | (n1.ren & p1.ren) |
			(n2.wen & p2.wen) | (n2.ren & p2.ren);
		// Clear beats a coincident violation
		if (clr) begin
			exp_status = '0;
		end else if (exp_hog) begin
			exp_status.sticky = 1'b1;
			if (exp_status.count != {cnt_w{1'b1}}) begin
				exp_status.count = exp_status.count + 1'b1;
			end
		end
		// Reads see memory before this edge's write
		both_rd = n1.ren & n2.ren;
		v1 = n1.ren ? mem_model[n1.addr] : '0;
		v2 = (n2.ren & ~both_rd) ? mem_model[n2.addr] : '0;
		// Port 2 write held over from a double write
		if (p1.wen & p2.wen) begin
			mem_model[p2.addr] = p2.din;
		end
		if (n1.wen) begin
			mem_model[n1.addr] = n1.din;
		end else if (n2.wen) begin
			mem_model[n2.addr] = n2.din;
		end
		// Deferred port 2 read happens on the next edge, after these writes
		if (both_rd) begin
			v2 = mem_model[n2.addr];
		end
		line1    = v1;
		line2[1] = line2[0];
		line2[0] = v2;
		p1 = n1;
		p2 = n2;
	endtask

	// One clock cycle of traffic
	task automatic run_cycle(input mem_req_t n1, input mem_req_t n2, input logic clr);
		@(negedge clk);
		check_value("dout1", 32'(dout1), 32'(line1));
		check_value("dout2", 32'(dout2), 32'(line2[1]));
		check_value("status", 32'(status), 32'(exp_status));
		req1      = n1;
		req2      = n2;
		hog_clear = clr;
		model_edge(n1, n2, clr);
		// hog_err follows the inputs, look before the rising edge
		#2;
		check_value("hog_err", 32'(hog_err), 32'(exp_hog));
	endtask

	initial begin
		mem_req_t    n1;
		mem_req_t    n2;
		logic [31:0] b;
		int          tries;
		arst_n     = 1'b0;
		req1       = '0;
		req2       = '0;
		hog_clear  = 1'b0;
		lfsr       = 32'h16e4;
		p1         = '0;
		p2         = '0;
		exp_hog    = 1'b0;
		exp_status = '0;
		line1      = '0;
		line2[0]   = '0;
		line2[1]   = '0;
		repeat (8) @(posedge clk);
		@(negedge clk);
		arst_n = 1'b1;

		// Fill every word, the ports take turns
		for (int a = 0; a < mem_depth; a++) begin
			n1 = '0;
			n1.addr = a[mem_aw-1:0];
			b = take_bits(mem_dw);
			n1.din = b[mem_dw-1:0];
			n1.wen = 1'b1;
			if (a[0]) begin
				run_cycle('0, n1, 1'b0);
			end else begin
				run_cycle(n1, '0, 1'b0);
			end
		end

		// Legal traffic, a quarter of the cycles share one address
		for (int i = 0; i < 4000; i++) begin
			n1 = random_req(p1, 1'b1);
			n2 = random_req(p2, 1'b1);
			b = take_bits(2);
			if (b[1:0] == 2'b00) begin
				n2.addr = n1.addr;
			end
			run_cycle(n1, n2, 1'b0);
		end
		repeat (2) run_cycle('0, '0, 1'b0);

		// Port 1 reads every cycle until the count saturates
		tries = 0;
		while (status.count != {cnt_w{1'b1}}) begin
			if (tries == 400) begin
				$display("status count never reached 255 under repeated port 1 reads");
				$display("Testbench failed");
				$fatal(1, "timeout");
			end
			n1 = random_req(p1, 1'b0);
			n1.wen = 1'b0;
			n1.ren = 1'b1;
			run_cycle(n1, '0, 1'b0);
			tries++;
		end
		// Count holds at the top, then a clear lands on a violation
		repeat (4) run_cycle(n1, '0, 1'b0);
		run_cycle(n1, '0, 1'b1);
		repeat (2) run_cycle('0, '0, 1'b0);

		// One port per cycle, repeats allowed, random clears
		for (int i = 0; i < 600; i++) begin
			n1 = random_req('0, 1'b0);
			b = take_bits(4);
			if (b[0]) begin
				run_cycle(n1, '0, b[3:1] == 3'b000);
			end else begin
				run_cycle('0, n1, b[3:1] == 3'b000);
			end
		end
		repeat (3) run_cycle('0, '0, 1'b0);

		$display("Testbench passed");
		$finish;
	end

endmodule

// File: verification/shared_mem_asserts.sv
// --------------------
// Fake dual-port assertions
// Hog flag, idle port 1 output and
// deferred write placement in the arbiter
// --------------------

`timescale 1ns/1ps

module shared_mem_asserts (
	input logic                              clk,
	input logic                              arst_n,
	input shared_mem_pkg::mem_req_t          req1,
	input shared_mem_pkg::mem_req_t          req2,
	input logic [shared_mem_pkg::mem_dw-1:0] dout1,
	input logic                              hog_err,
	input logic                              ram_wen,
	input logic [shared_mem_pkg::mem_aw-1:0] ram_waddr,
	input logic [shared_mem_pkg::mem_dw-1:0] ram_wdata
);

	// Flag equals a strobe repeated from the last cycle
	hog_matches_repeat: assert property (@(posedge clk) disable iff (!arst_n)
		hog_err == ((req1.wen & $past(req1.wen)) | (req1.ren & $past(req1.ren)) |
			(req2.wen & $past(req2.wen)) | (req2.ren & $past(req2.ren))))
		else $error("hog_err disagrees with the repeated strobes");

	// No port 1 read means zero on dout1 next cycle
	dout1_idle_zero: assert property (@(posedge clk) disable iff (!arst_n)
		!req1.ren |=> dout1 == '0)
		else $error("dout1 not zero after a cycle without a port 1 read");

	// Double write hands port 2's held request to the RAM next cycle
	deferred_lands: assert property (@(posedge clk) disable iff (!arst_n)
		(req1.wen & req2.wen) |=> ram_wen && ram_waddr == $past(req2.addr) &&
			ram_wdata == $past(req2.din))
		else $error("deferred port 2 write missing from the RAM write port");

endmodule

bind fake_dpram shared_mem_asserts u_asserts (
	.clk       (clk),
	.arst_n    (arst_n),
	.req1      (req1),
	.req2      (req2),
	.dout1     (dout1),
	.hog_err   (hog_err),
	.ram_wen   (ram_wen),
	.ram_waddr (ram_waddr),
	.ram_wdata (ram_wdata)
);

// File: logic/shared_mem_top.sv
// --------------------
// Shared scratch memory top
// Two client ports on one time-shared RAM
// plus a monitor for hog rule violations
// --------------------

`timescale 1ns/1ps

module shared_mem_top (
	input  logic                              clk,
	input  logic                              arst_n,
	// Client ports
	input  shared_mem_pkg::mem_req_t          req1,
	input  shared_mem_pkg::mem_req_t          req2,
	// Software clear of the status
	input  logic                              hog_clear,
	// Port 1 data, one cycle latency
	output logic [shared_mem_pkg::mem_dw-1:0] dout1,
	// Port 2 data, two cycles latency
	output logic [shared_mem_pkg::mem_dw-1:0] dout2,
	// Raw violation pulse
	output logic                              hog_err,
	// Latched violation status
	output shared_mem_pkg::hog_status_t       status
);

	// Arbiter and RAM
	fake_dpram u_fake_dpram (
		.clk     (clk),
		.arst_n  (arst_n),
		.req1    (req1),
		.req2    (req2),
		.dout1   (dout1),
		.dout2   (dout2),
		.hog_err (hog_err)
	);

	// Pulse also feeds the monitor
	hog_monitor u_hog_monitor (
		.clk       (clk),
		.arst_n    (arst_n),
		.hog_err   (hog_err),
		.hog_clear (hog_clear),
		.status    (status)
	);

endmodule

// File: logic/hog_monitor.sv
// --------------------
// Hog rule monitor
// Latches violation pulses into a sticky flag
// and a saturating count, cleared by a strobe
// --------------------

`timescale 1ns/1ps

module hog_monitor (
	input  logic                        clk,
	input  logic                        arst_n,
	// Violation pulse from the arbiter
	input  logic                        hog_err,
	// Software clear, wins over a violation
	input  logic                        hog_clear,
	// Flag and count
	output shared_mem_pkg::hog_status_t status
);

	import shared_mem_pkg::*;

	// Count at its ceiling
	logic cnt_full;

	assign cnt_full = (status.count == {cnt_w{1'b1}});

	// Status register
	// Update shows at the edge of the violation
	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			status.sticky <= 1'b0;
			status.count  <= '0;
		end else if (hog_clear) begin
			// Clear first, a coincident pulse is dropped
			status.sticky <= 1'b0;
			status.count  <= '0;
		end else if (hog_err) begin
			status.sticky <= 1'b1;
			// Hold at the top instead of wrapping
			if (!cnt_full) begin
				status.count <= status.count + 1'b1;
			end
		end
	end

endmodule

// File: logic/fake_dpram.sv
// --------------------
// Fake dual-port memory
// Time-shares one simple dual-port RAM between two
// strobe ports, port 1 has priority and one cycle of
// read latency, port 2 gets two, hog rule is flagged
// --------------------

`timescale 1ns/1ps

module fake_dpram (
	input  logic                              clk,
	input  logic                              arst_n,
	// Client port 1
	input  shared_mem_pkg::mem_req_t          req1,
	// Client port 2
	input  shared_mem_pkg::mem_req_t          req2,
	// Port 1 read data, one cycle after the strobe
	output logic [shared_mem_pkg::mem_dw-1:0] dout1,
	// Port 2 read data, two cycles after the strobe
	output logic [shared_mem_pkg::mem_dw-1:0] dout2,
	// Same strobe seen two cycles in a row
	output logic                              hog_err
);

	import shared_mem_pkg::*;

	// Port 2 request held for a deferred access
	logic [mem_aw-1:0] addr2_d;
	logic [mem_dw-1:0] din2_d;

	// Strobes of the previous cycle
	logic wen1_d;
	logic ren1_d;
	logic wen2_d;
	logic ren2_d;

	// Read strobes two cycles back, for port 2 alignment
	logic ren1_dd;
	logic ren2_dd;

	// RAM side
	logic [mem_aw-1:0] ram_waddr;
	logic [mem_dw-1:0] ram_wdata;
	logic              ram_wen;
	logic [mem_aw-1:0] ram_raddr;
	logic [mem_dw-1:0] ram_rdata;

	// RAM output one cycle later
	logic [mem_dw-1:0] ram_rdata_d;

	// Payload copy of port 2, no reset needed
	always_ff @(posedge clk) begin
		addr2_d <= req2.addr;
		din2_d  <= req2.din;
	end

	// Strobe history
	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			wen1_d  <= 1'b0;
			ren1_d  <= 1'b0;
			wen2_d  <= 1'b0;
			ren2_d  <= 1'b0;
			ren1_dd <= 1'b0;
			ren2_dd <= 1'b0;
		end else begin
			wen1_d  <= req1.wen;
			ren1_d  <= req1.ren;
			wen2_d  <= req2.wen;
			ren2_d  <= req2.ren;
			ren1_dd <= ren1_d;
			ren2_dd <= ren2_d;
		end
	end

	// Write steering, port 1 first
	// Port 2 falls back to its held request
	// when both wrote in the last cycle
	always_comb begin
		if (req1.wen) begin
			ram_waddr = req1.addr;
			ram_wdata = req1.din;
		end else if (req2.wen) begin
			ram_waddr = req2.addr;
			ram_wdata = req2.din;
		end else begin
			ram_waddr = addr2_d;
			ram_wdata = din2_d;
		end
	end

	assign ram_wen = req1.wen | req2.wen | (wen1_d & wen2_d);

	// Read steering, same priority
	// Idle cycles read the held port 2 address,
	// which is the deferred read when there is one
	always_comb begin
		if (req1.ren) begin
			ram_raddr = req1.addr;
		end else if (req2.ren) begin
			ram_raddr = req2.addr;
		end else begin
			ram_raddr = addr2_d;
		end
	end

	dpram mem (
		.clk   (clk),
		.waddr (ram_waddr),
		.wdata (ram_wdata),
		.wen   (ram_wen),
		.raddr (ram_raddr),
		.rdata (ram_rdata)
	);

	// Extra stage for a port 2 read that went first
	always_ff @(posedge clk) begin
		ram_rdata_d <= ram_rdata;
	end

	// Port 1 sees the RAM output directly
	assign dout1 = ren1_d ? ram_rdata : '0;

	// Port 2 takes the RAM output as is when its read was deferred,
	// otherwise the delayed copy
	always_comb begin
		if (!ren2_dd) begin
			dout2 = '0;
		end else if (ren1_dd) begin
			dout2 = ram_rdata;
		end else begin
			dout2 = ram_rdata_d;
		end
	end

	// Flag any repeated strobe, harmful or not
	assign hog_err = (req1.wen & wen1_d) | (req1.ren & ren1_d) |
		(req2.wen & wen2_d) | (req2.ren & ren2_d);

endmodule

// File: logic/dpram.sv
// --------------------
// Simple dual-port RAM
// One synchronous write port and one read port
// with a registered read-first output
// --------------------

`timescale 1ns/1ps

module dpram (
	input  logic                              clk,
	// Write port
	input  logic [shared_mem_pkg::mem_aw-1:0] waddr,
	input  logic [shared_mem_pkg::mem_dw-1:0] wdata,
	input  logic                              wen,
	// Read port, reads every cycle
	input  logic [shared_mem_pkg::mem_aw-1:0] raddr,
	output logic [shared_mem_pkg::mem_dw-1:0] rdata
);

	import shared_mem_pkg::*;

	// Storage array, contents not initialized
	logic [mem_dw-1:0] mem [mem_depth];

	// Write lands at the edge where wen is high
	always_ff @(posedge clk) begin
		if (wen) begin
			mem[waddr] <= wdata;
		end
	end

	// Registered read, one clock after the address
	// Same-address collision returns the old word
	always_ff @(posedge clk) begin
		rdata <= mem[raddr];
	end

endmodule

// File: logic/shared_mem_pkg.sv
// --------------------
// Shared scratch memory package
// Widths of the time-shared RAM and the
// client request and hog status words
// --------------------

package shared_mem_pkg;

	// Address width, fixes the RAM depth
	localparam int mem_aw = 9;

	// Data width of one RAM word
	localparam int mem_dw = 8;

	// Number of words in the RAM
	localparam int mem_depth = 1 << mem_aw;

	// Width of the hog violation counter
	localparam int cnt_w = 8;

	// One client port request
	// A single address serves both read and write
	// Strobes are one cycle wide, never two in a row
	typedef struct packed {
		// Word address
		logic [mem_aw-1:0] addr;
		// Write data, only looked at with wen
		logic [mem_dw-1:0] din;
		// Write strobe
		logic              wen;
		// Read strobe
		logic              ren;
	} mem_req_t;

	// Hog rule status for software to poll
	typedef struct packed {
		// Set by any violation, held until clear
		logic             sticky;
		// Violations since reset or clear, saturating
		logic [cnt_w-1:0] count;
	} hog_status_t;

endpackage
